// File: Makefile
# Verilator build for the crossbar testbench

VERILATOR ?= verilator
TOP       ?= tb_xbar
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
xbar_pkg.sv
xbar_target_decode.sv
xbar_port_arbiter.sv
xbar_resp_return.sv
xbar_top.sv
xbar_assertions.sv
tb_xbar.sv

// File: tb_xbar.sv
//------------------------------------------------
// Crossbar testbench
// Five target models and directed tests
//------------------------------------------------
`timescale 1ns/1ns

module tb_xbar;

    import xbar_pkg::*;

    localparam int TIMEOUT = 60;

    logic                 clk;
    logic                 rst_n;
    logic [1:0]           bypass_cache;
    mem_req_t             imem_req;
    mem_req_t             dmem_req;
    logic                 imem_req_ack;
    logic                 dmem_req_ack;
    mem_rsp_t             imem_rsp;
    mem_rsp_t             dmem_rsp;
    mem_req_t             port_req [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_req_ack;
    mem_rsp_t             port_rsp [NUM_PORTS];
    logic [31:0]          last_addr [NUM_PORTS];
    int                   seed = 32'h2503;
    int                   cyc;
    int                   errors;
    int                   tests_run;
    int                   tests_bad;

    xbar_top DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] port_key(input int p);
        case (p)
            0: return 32'h5A5A_0000;
            1: return 32'h1234_1111;
            2: return 32'hC3C3_2222;
            3: return 32'h0F0F_3333;
            default: return 32'hA5A5_4444;
        endcase
    endfunction

    //------------------------------------------------
    // Target models with random ack and response delays
    //------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_model
        logic        busy = 1'b0;
        logic        ack_ok = 1'b0;
        int          ack_wait = 0;
        int          draw;
        int          cnt = 0;
        mem_rsp_t    rsp_q = '0;
        logic [31:0] addr_q = '0;

        assign port_req_ack[p] = port_req[p].req && ack_ok;
        assign port_rsp[p]     = rsp_q;
        assign last_addr[p]    = addr_q;

        always @(posedge clk) begin
            if (!rst_n) begin
                busy   <= 1'b0;
                ack_ok <= 1'b0;
                rsp_q  <= '0;
            end else begin
                rsp_q <= '0;
                if (port_req_ack[p]) begin
                    busy   <= 1'b1;
                    ack_ok <= 1'b0;
                    addr_q <= port_req[p].addr;
                    cnt    <= 1 + int'($unsigned($random(seed)) % 3);
                end else if (busy) begin
                    cnt <= cnt - 1;
                    if (cnt == 1) begin
                        busy     <= 1'b0;
                        rsp_q    <= '{rdata: addr_q ^ port_key(p), resp: MEM_RESP_OK};
                        // Ack delay of 0 to 3 cycles for the next request
                        draw      = int'($unsigned($random(seed)) % 4);
                        ack_ok   <= (draw == 0);
                        ack_wait <= (draw > 0) ? draw - 1 : 0;
                    end
                end else if (port_req[p].req && !ack_ok) begin
                    if (ack_wait == 0) begin
                        ack_ok <= 1'b1;
                    end else begin
                        ack_wait <= ack_wait - 1;
                    end
                end
            end
        end
    end

    //------------------------------------------------
    // Master side helpers
    //------------------------------------------------
    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic drive_req(input bit dm, input logic [31:0] addr);
        mem_req_t r;
        r = '{req: 1'b1, cmd: MEM_CMD_READ, width: MEM_WIDTH_WORD, addr: addr, wdata: '0};
        @(posedge clk);
        if (dm) dmem_req <= r;
        else imem_req <= r;
    endtask

    task automatic wait_ack(input bit dm, output int c);
        int t;
        t = 0;
        @(negedge clk);
        while (!(dm ? dmem_req_ack : imem_req_ack)) begin
            t++;
            if (t > TIMEOUT) abort_run("req_ack");
            @(negedge clk);
        end
        c = cyc;
    endtask

    // Reports the master response cycle as mc and the port response cycle as pc
    task automatic wait_rsp(input bit dm, input int port, output logic [31:0] rd,
                            output int mc, output int pc);
        int       t;
        mem_rsp_t r;
        t  = 0;
        pc = -1;
        @(negedge clk);
        r = dm ? dmem_rsp : imem_rsp;
        while (r.resp == MEM_RESP_IDLE) begin
            if (port_rsp[port].resp != MEM_RESP_IDLE) pc = cyc;
            t++;
            if (t > TIMEOUT) abort_run("a response");
            @(negedge clk);
            r = dm ? dmem_rsp : imem_rsp;
        end
        if (port_rsp[port].resp != MEM_RESP_IDLE) pc = cyc;
        mc = cyc;
        rd = r.rdata;
        check_value(dm ? "dmem_rsp.resp" : "imem_rsp.resp", 32'(r.resp), 32'(MEM_RESP_OK));
    endtask

    // One read from request to response with data and port checks
    task automatic xfer(input bit dm, input logic [31:0] addr, input int port,
                        output int ac, output int mc, output int pc);
        logic [31:0] rd;
        drive_req(dm, addr);
        wait_ack(dm, ac);
        @(posedge clk);
        if (dm) dmem_req.req <= 1'b0;
        else imem_req.req <= 1'b0;
        wait_rsp(dm, port, rd, mc, pc);
        check_value($sformatf("rdata port%0d", port), rd, addr ^ port_key(port));
        check_value($sformatf("last_addr[%0d]", port), last_addr[port], addr);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
            tests_bad++;
        end
    endtask

    //------------------------------------------------
    // Directed tests
    //------------------------------------------------
    task automatic route_by_address();
        logic [31:0] addrs [NUM_PORTS];
        int e, ac, mc, pc;
        e = errors;
        addrs = '{32'h2000_0000, 32'h0000_1000, 32'h0800_2000, 32'h0C48_0100, 32'h0C49_0004};
        for (int p = 0; p < NUM_PORTS; p++) xfer(1'b1, addrs[p], p, ac, mc, pc);
        end_test("decode", e);
    endtask

    task automatic bypass_to_dmem();
        int e, ac, mc, pc;
        e = errors;
        @(posedge clk);
        bypass_cache <= 2'b01;
        xfer(1'b0, 32'h0000_1040, 0, ac, mc, pc);
        @(posedge clk);
        bypass_cache <= 2'b10;
        xfer(1'b1, 32'h0800_2040, 0, ac, mc, pc);
        @(posedge clk);
        bypass_cache <= 2'b00;
        end_test("bypass", e);
    endtask

    task automatic response_timing();
        int e, ac, mc, pc;
        e = errors;
        xfer(1'b0, 32'h0C48_0200, 3, ac, mc, pc);
        check_value("imem_rsp cycle", 32'(mc), 32'(pc));
        xfer(1'b1, 32'h0C49_0008, 4, ac, mc, pc);
        check_value("dmem_rsp cycle", 32'(mc), 32'(pc + 1));
        end_test("timing", e);
    endtask

    task automatic parallel_ports();
        int e, iac, imc, ipc, dac, dmc, dpc;
        e = errors;
        fork
            xfer(1'b0, 32'h0000_2000, 1, iac, imc, ipc);
            xfer(1'b1, 32'h0C48_0300, 3, dac, dmc, dpc);
        join
        end_test("concurrency", e);
    endtask

    task automatic shared_port_order();
        int e, iac, imc, ipc, dac, dmc, dpc;
        e = errors;
        fork
            xfer(1'b0, 32'h0C48_0400, 3, iac, imc, ipc);
            xfer(1'b1, 32'h0C48_0500, 3, dac, dmc, dpc);
        join
        // imem may only get port 3 once the dmem port response has passed
        assert (iac > dpc) else begin
            $display("imem was granted port 3 before dmem's port response");
            errors++;
        end
        end_test("contention", e);
    endtask

    task automatic lock_until_response();
        int          e, t, ac, mc, pc;
        logic [31:0] rd;
        e = errors;
        t = 0;
        drive_req(1'b1, 32'h0C48_0600);
        wait_ack(1'b1, ac);
        @(posedge clk);
        dmem_req.addr <= 32'h0C49_0010;
        @(negedge clk);
        while (dmem_rsp.resp == MEM_RESP_IDLE) begin
            assert (!dmem_req_ack) else begin
                $display("second req_ack before the first response");
                errors++;
            end
            t++;
            if (t > TIMEOUT) abort_run("the locked response");
            @(negedge clk);
        end
        check_value("dmem_rsp.rdata", dmem_rsp.rdata, 32'h0C48_0600 ^ port_key(3));
        if (!dmem_req_ack) wait_ack(1'b1, ac);
        @(posedge clk);
        dmem_req.req <= 1'b0;
        wait_rsp(1'b1, 4, rd, mc, pc);
        check_value("dmem_rsp.rdata", rd, 32'h0C49_0010 ^ port_key(4));
        check_value("last_addr[4]", last_addr[4], 32'h0C49_0010);
        end_test("lock", e);
    endtask

    initial begin
        rst_n        = 1'b0;
        bypass_cache = 2'b00;
        imem_req     = '0;
        dmem_req     = '0;
        cyc          = 0;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        route_by_address();
        bypass_to_dmem();
        response_timing();
        parallel_ports();
        shared_port_order();
        lock_until_response();
        $display("Tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: xbar_assertions.sv
//------------------------------------------------
// Crossbar protocol assertions
// Bound into the crossbar top level
//------------------------------------------------
`timescale 1ns/1ns

module xbar_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input xbar_pkg::mem_req_t                imem_req,
    input xbar_pkg::mem_req_t                dmem_req,
    input logic                              imem_req_ack,
    input logic                              dmem_req_ack,
    input xbar_pkg::mem_rsp_t                imem_rsp,
    input xbar_pkg::mem_rsp_t                dmem_rsp,
    input xbar_pkg::mem_req_t                port_req [xbar_pkg::NUM_PORTS],
    input logic [xbar_pkg::NUM_PORTS-1:0]    port_req_ack,
    input xbar_pkg::mem_rsp_t                port_rsp [xbar_pkg::NUM_PORTS]
);

    import xbar_pkg::*;

    logic imem_pend;
    logic dmem_pend;

    // Outstanding transaction per master
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_pend <= 1'b0;
            dmem_pend <= 1'b0;
        end else begin
            if (imem_req.req && imem_req_ack) imem_pend <= 1'b1;
            else if (imem_rsp.resp != MEM_RESP_IDLE) imem_pend <= 1'b0;
            if (dmem_req.req && dmem_req_ack) dmem_pend <= 1'b1;
            else if (dmem_rsp.resp != MEM_RESP_IDLE) dmem_pend <= 1'b0;
        end
    end

    a_imem_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        imem_rsp.resp != MEM_RESP_IDLE |-> imem_pend) else $error("imem response not pending");
    a_dmem_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_rsp.resp != MEM_RESP_IDLE |-> dmem_pend) else $error("dmem response not pending");
    a_imem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req.req && !imem_req_ack |=> $stable(imem_req)) else $error("imem request moved");
    a_dmem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req.req && !dmem_req_ack |=> $stable(dmem_req)) else $error("dmem request moved");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic busy;

        always @(posedge clk) begin
            if (!rst_n) busy <= 1'b0;
            else if (port_req[p].req && port_req_ack[p]) busy <= 1'b1;
            else if (port_rsp[p].resp != MEM_RESP_IDLE) busy <= 1'b0;
        end

        a_busy: assert property (@(posedge clk) disable iff (!rst_n)
            busy |-> !port_req[p].req) else $error("port %0d request while busy", p);
    end

endmodule

bind xbar_top xbar_assertions u_assertions (.*);

// File: xbar_pkg.sv
//------------------------------------------------
// Memory crossbar package
// Widths, address map, bus enums and the request
// and response structs shared by the crossbar
//------------------------------------------------
package xbar_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_PORTS   = 5;
    localparam int NUM_MASTERS = 2;

    // Master index into per-master vectors
    localparam int MST_IMEM = 0;
    localparam int MST_DMEM = 1;

    //------------------------------------------------
    // Address map
    //------------------------------------------------
    // Icache 0x0000_0000 - 0x07FF_FFFF
    localparam logic [ADDR_W-1:0] ICACHE_ADDR_MASK    = 32'hF800_0000;
    localparam logic [ADDR_W-1:0] ICACHE_ADDR_PATTERN = 32'h0000_0000;
    // Dcache 0x0800_0000 - 0x0BFF_FFFF
    localparam logic [ADDR_W-1:0] DCACHE_ADDR_MASK    = 32'hFC00_0000;
    localparam logic [ADDR_W-1:0] DCACHE_ADDR_PATTERN = 32'h0800_0000;
    // TCM, one 64 KB page
    localparam logic [ADDR_W-1:0] TCM_ADDR_MASK       = 32'hFFFF_0000;
    localparam logic [ADDR_W-1:0] TCM_ADDR_PATTERN    = 32'h0C48_0000;
    // Timer, 32-byte register window
    localparam logic [ADDR_W-1:0] TIMER_ADDR_MASK     = 32'hFFFF_FFE0;
    localparam logic [ADDR_W-1:0] TIMER_ADDR_PATTERN  = 32'h0C49_0000;

    //------------------------------------------------
    // Encodings
    //------------------------------------------------
    // Target id
    typedef enum logic [2:0] {
        PORT_DMEM   = 3'd0,
        PORT_ICACHE = 3'd1,
        PORT_DCACHE = 3'd2,
        PORT_TCM    = 3'd3,
        PORT_TIMER  = 3'd4
    } port_sel_e;

    typedef enum logic {
        MEM_CMD_READ  = 1'b0,
        MEM_CMD_WRITE = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE = 2'd0,
        MEM_WIDTH_HALF = 2'd1,
        MEM_WIDTH_WORD = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE = 2'd0,
        MEM_RESP_OK   = 2'd1,
        MEM_RESP_ERR  = 2'd2
    } mem_resp_e;

    // Request bundle, 68 bits
    typedef struct packed {
        logic              req;
        mem_cmd_e          cmd;
        mem_width_e        width;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Response bundle, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        mem_resp_e         resp;
    } mem_rsp_t;

    localparam mem_rsp_t RSP_IDLE = '{rdata: '0, resp: MEM_RESP_IDLE};

endpackage

// File: xbar_port_arbiter.sv
//------------------------------------------------
// Crossbar port arbiter
// Grants one master to a target port and steers
// the port response back to that master
//------------------------------------------------
`timescale 1ns/1ns

module xbar_port_arbiter #(
    parameter xbar_pkg::port_sel_e PORT_ID = xbar_pkg::PORT_DMEM
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  xbar_pkg::mem_req_t                  imem_req,
    input  xbar_pkg::mem_req_t                  dmem_req,
    input  xbar_pkg::port_sel_e                 imem_tid,
    input  xbar_pkg::port_sel_e                 dmem_tid,
    output logic [xbar_pkg::NUM_MASTERS-1:0]    ack,
    output xbar_pkg::mem_rsp_t                  imem_rsp,
    output xbar_pkg::mem_rsp_t                  dmem_rsp,
    output xbar_pkg::mem_req_t                  port_req,
    input  logic                                port_req_ack,
    input  xbar_pkg::mem_rsp_t                  port_rsp
);

    import xbar_pkg::*;

    logic busy;
    logic owner_dmem;
    logic imem_hit;
    logic dmem_hit;
    logic grant_dmem;
    logic grant_any;
    logic accept;
    logic rsp_seen;

    //------------------------------------------------
    // Grant
    //------------------------------------------------
    assign imem_hit = imem_req.req && (imem_tid == PORT_ID);
    assign dmem_hit = dmem_req.req && (dmem_tid == PORT_ID);

    // dmem wins when both hit in the same cycle
    assign grant_dmem = dmem_hit;
    assign grant_any  = !busy && (imem_hit || dmem_hit);

    always_comb begin
        port_req     = grant_dmem ? dmem_req : imem_req;
        port_req.req = grant_any;
    end

    assign ack[MST_DMEM] = grant_any && grant_dmem && port_req_ack;
    assign ack[MST_IMEM] = grant_any && !grant_dmem && port_req_ack;

    //------------------------------------------------
    // Ownership
    //------------------------------------------------
    assign accept   = grant_any && port_req_ack;
    assign rsp_seen = busy && (port_rsp.resp != MEM_RESP_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            owner_dmem <= 1'b0;
        end else if (accept) begin
            busy       <= 1'b1;
            owner_dmem <= grant_dmem;
        end else if (rsp_seen) begin
            busy       <= 1'b0;
        end
    end

    // Response goes to the owner only
    assign imem_rsp = (busy && !owner_dmem) ? port_rsp : RSP_IDLE;
    assign dmem_rsp = (busy && owner_dmem) ? port_rsp : RSP_IDLE;

endmodule

// File: xbar_resp_return.sv
//------------------------------------------------
// Crossbar response return
// Picks ack and response for one master from the
// port its target id names
//------------------------------------------------
`timescale 1ns/1ns

module xbar_resp_return #(
    parameter bit RSP_REG = 1'b0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  xbar_pkg::port_sel_e               target_id,
    input  logic [xbar_pkg::NUM_PORTS-1:0]    port_ack,
    input  xbar_pkg::mem_rsp_t                port_rsp [xbar_pkg::NUM_PORTS],
    output logic                              req_ack,
    output logic                              done,
    output xbar_pkg::mem_rsp_t                master_rsp
);

    import xbar_pkg::*;

    mem_rsp_t rsp_sel;

    // Port select by target id
    always_comb begin
        req_ack = 1'b0;
        rsp_sel = RSP_IDLE;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (target_id == port_sel_e'(p)) begin
                req_ack = port_ack[p];
                rsp_sel = port_rsp[p];
            end
        end
    end

    // Unregistered response beat, releases the decode lock
    assign done = (rsp_sel.resp != MEM_RESP_IDLE);

    //------------------------------------------------
    // Output stage
    //------------------------------------------------
    generate
        if (RSP_REG) begin : g_rsp_reg
            mem_rsp_t rsp_q;

            // One cycle timing break on the response path
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    rsp_q <= RSP_IDLE;
                end else begin
                    rsp_q <= rsp_sel;
                end
            end

            assign master_rsp = rsp_q;
        end else begin : g_rsp_comb
            assign master_rsp = rsp_sel;
        end
    endgenerate

endmodule

// File: xbar_target_decode.sv
//------------------------------------------------
// Crossbar target decode
// Maps a master address to a target port and
// holds that target until the response returns
//------------------------------------------------
`timescale 1ns/1ns

module xbar_target_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [1:0]            bypass_cache,
    input  xbar_pkg::mem_req_t    master_req,
    input  logic                  req_ack,
    input  logic                  done,
    output xbar_pkg::mem_req_t    fwd_req,
    output xbar_pkg::port_sel_e   target_id
);

    import xbar_pkg::*;

    logic      lock;
    logic      accept;
    port_sel_e tid_dec;
    port_sel_e tid_held;

    //------------------------------------------------
    // Address decode
    //------------------------------------------------
    // Priority icache, dcache, TCM, timer, then default dmem
    always_comb begin
        tid_dec = PORT_DMEM;
        if (((master_req.addr & ICACHE_ADDR_MASK) == ICACHE_ADDR_PATTERN) &&
            !bypass_cache[0]) begin
            tid_dec = PORT_ICACHE;
        end else if (((master_req.addr & DCACHE_ADDR_MASK) == DCACHE_ADDR_PATTERN) &&
                     !bypass_cache[1]) begin
            tid_dec = PORT_DCACHE;
        end else if ((master_req.addr & TCM_ADDR_MASK) == TCM_ADDR_PATTERN) begin
            tid_dec = PORT_TCM;
        end else if ((master_req.addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN) begin
            tid_dec = PORT_TIMER;
        end
    end

    //------------------------------------------------
    // Target lock
    //------------------------------------------------
    assign accept = fwd_req.req && req_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lock <= 1'b0;
        end else if (accept) begin
            lock <= 1'b1;
        end else if (done) begin
            lock <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tid_held <= tid_dec;
        end
    end

    // Held id keeps the response path pointed at the right port
    assign target_id = lock ? tid_held : tid_dec;

    // No new request leaves while one is pending
    always_comb begin
        fwd_req     = master_req;
        fwd_req.req = master_req.req && !lock;
    end

endmodule

// File: xbar_top.sv
//------------------------------------------------
// Memory crossbar top
// Routes imem and dmem to five target ports
//------------------------------------------------
`timescale 1ns/1ns

module xbar_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [1:0]                        bypass_cache,
    input  xbar_pkg::mem_req_t                imem_req,
    input  xbar_pkg::mem_req_t                dmem_req,
    output logic                              imem_req_ack,
    output logic                              dmem_req_ack,
    output xbar_pkg::mem_rsp_t                imem_rsp,
    output xbar_pkg::mem_rsp_t                dmem_rsp,
    output xbar_pkg::mem_req_t                port_req [xbar_pkg::NUM_PORTS],
    input  logic [xbar_pkg::NUM_PORTS-1:0]    port_req_ack,
    input  xbar_pkg::mem_rsp_t                port_rsp [xbar_pkg::NUM_PORTS]
);

    import xbar_pkg::*;

    mem_req_t               imem_fwd;
    mem_req_t               dmem_fwd;
    port_sel_e              imem_tid;
    port_sel_e              dmem_tid;
    logic                   imem_done;
    logic                   dmem_done;
    logic [NUM_MASTERS-1:0] arb_ack [NUM_PORTS];
    logic [NUM_PORTS-1:0]   imem_port_ack;
    logic [NUM_PORTS-1:0]   dmem_port_ack;
    mem_rsp_t               imem_port_rsp [NUM_PORTS];
    mem_rsp_t               dmem_port_rsp [NUM_PORTS];

    //------------------------------------------------
    // Target decode, one per master
    //------------------------------------------------
    xbar_target_decode u_imem_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .bypass_cache (bypass_cache),
        .master_req   (imem_req),
        .req_ack      (imem_req_ack),
        .done         (imem_done),
        .fwd_req      (imem_fwd),
        .target_id    (imem_tid)
    );

    xbar_target_decode u_dmem_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .bypass_cache (bypass_cache),
        .master_req   (dmem_req),
        .req_ack      (dmem_req_ack),
        .done         (dmem_done),
        .fwd_req      (dmem_fwd),
        .target_id    (dmem_tid)
    );

    //------------------------------------------------
    // Port arbiters
    //------------------------------------------------
    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            xbar_port_arbiter #(
                .PORT_ID (port_sel_e'(p))
            ) u_arbiter (
                .clk          (clk),
                .rst_n        (rst_n),
                .imem_req     (imem_fwd),
                .dmem_req     (dmem_fwd),
                .imem_tid     (imem_tid),
                .dmem_tid     (dmem_tid),
                .ack          (arb_ack[p]),
                .imem_rsp     (imem_port_rsp[p]),
                .dmem_rsp     (dmem_port_rsp[p]),
                .port_req     (port_req[p]),
                .port_req_ack (port_req_ack[p]),
                .port_rsp     (port_rsp[p])
            );

            // Regroup acks per master
            assign imem_port_ack[p] = arb_ack[p][MST_IMEM];
            assign dmem_port_ack[p] = arb_ack[p][MST_DMEM];
        end
    endgenerate

    //------------------------------------------------
    // Response return, dmem side registered
    //------------------------------------------------
    xbar_resp_return #(.RSP_REG(1'b0)) u_imem_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .target_id  (imem_tid),
        .port_ack   (imem_port_ack),
        .port_rsp   (imem_port_rsp),
        .req_ack    (imem_req_ack),
        .done       (imem_done),
        .master_rsp (imem_rsp)
    );

    xbar_resp_return #(.RSP_REG(1'b1)) u_dmem_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .target_id  (dmem_tid),
        .port_ack   (dmem_port_ack),
        .port_rsp   (dmem_port_rsp),
        .req_ack    (dmem_req_ack),
        .done       (dmem_done),
        .master_rsp (dmem_rsp)
    );

endmodule
